// ==== design/matrix_log_pkg.sv ====
/*
 * Shared constants for the matrix log engine
 * Data, index, result field and FIFO sizes
 * State enums for the sequencer and the log unit FSMs
 */

package matrix_log_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Input element and result word
  localparam int DATA_SIZE = 32;

  // Matrix sizes and row/column indices, sizes 1 to 255
  localparam int INDEX_SIZE = 8;

  // Result fields, leading-one position above left-aligned remainder
  localparam int LOG_INT_SIZE  = 5;
  localparam int LOG_FRAC_SIZE = 27;

  ////////////////////////////////////////////////////////////////////////////
  // Element FIFO
  ////////////////////////////////////////////////////////////////////////////

  // Depth is a power of two so the pointers wrap on their own
  localparam int FIFO_DEPTH     = 8;
  localparam int FIFO_ADDR_SIZE = 3;

  ////////////////////////////////////////////////////////////////////////////
  // FSM states
  ////////////////////////////////////////////////////////////////////////////

  // SEQ_ROW waits for an I strobe, SEQ_COL for a J strobe
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_ROW,
    SEQ_COL
  } seq_state_e;

  typedef enum logic [1:0] {
    LOG_IDLE,
    LOG_NORM,
    LOG_DONE
  } log_state_e;

endpackage

// ==== design/matrix_log_sequencer.sv ====
/*
 * Input sequencer for the matrix log engine
 * Walks rows and columns on the I/J strobes, tags each element
 * with row-last and matrix-last, and writes it into the FIFO
 * Drops elements on a full FIFO and keeps a sticky overflow flag
 */

module matrix_log_sequencer (
  input  logic                                  CLK,
  input  logic                                  RST,
  // Control
  input  logic                                  START,
  input  logic                                  DATA_IN_I_ENABLE,
  input  logic                                  DATA_IN_J_ENABLE,
  // Data
  input  logic [matrix_log_pkg::INDEX_SIZE-1:0] SIZE_I_IN,
  input  logic [matrix_log_pkg::INDEX_SIZE-1:0] SIZE_J_IN,
  input  logic [ matrix_log_pkg::DATA_SIZE-1:0] DATA_IN,
  // FIFO write side
  input  logic                                  full,
  output logic                                  push,
  output logic [ matrix_log_pkg::DATA_SIZE-1:0] push_data,
  output logic                                  push_row_last,
  output logic                                  push_matrix_last,
  // Status
  output logic                                  OVERFLOW
);

  import matrix_log_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  seq_state_e            state;

  // Sizes latched at START
  logic [INDEX_SIZE-1:0] size_i_r;
  logic [INDEX_SIZE-1:0] size_j_r;

  // Position of the element now expected
  logic [INDEX_SIZE-1:0] i_idx;
  logic [INDEX_SIZE-1:0] j_idx;

  logic                  start_take;
  logic                  take;
  logic                  row_last;
  logic                  matrix_last;

  // Element registered and waiting for its FIFO write
  logic                  pend_valid;
  logic                  drop;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  assign start_take = (state == SEQ_IDLE) && START;

  // Only the strobe of the expected kind counts
  assign take = ((state == SEQ_ROW) && DATA_IN_I_ENABLE) ||
                ((state == SEQ_COL) && DATA_IN_J_ENABLE);

  // Tags for the element taken this cycle
  assign row_last    = (j_idx == size_j_r - INDEX_SIZE'(1));
  assign matrix_last = row_last && (i_idx == size_i_r - INDEX_SIZE'(1));

  // Full is checked in the write cycle, so a push issued the cycle
  // before is already counted
  assign push = pend_valid && !full;
  assign drop = pend_valid && full;

  ////////////////////////////////////////////////////////////////////////////
  // Row and column FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= SEQ_IDLE;
      size_i_r <= '0;
      size_j_r <= '0;
      i_idx    <= '0;
      j_idx    <= '0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (START) begin
            size_i_r <= SIZE_I_IN;
            size_j_r <= SIZE_J_IN;
            i_idx    <= '0;
            j_idx    <= '0;
            state    <= SEQ_ROW;
          end
        end
        SEQ_ROW, SEQ_COL: begin
          // Indices advance even when the element gets dropped
          if (take) begin
            if (row_last) begin
              j_idx <= '0;
              if (matrix_last) begin
                state <= SEQ_IDLE;
              end else begin
                i_idx <= i_idx + INDEX_SIZE'(1);
                state <= SEQ_ROW;
              end
            end else begin
              j_idx <= j_idx + INDEX_SIZE'(1);
              state <= SEQ_COL;
            end
          end
        end
        default: begin
          state <= SEQ_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write request and overflow
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      pend_valid <= 1'b0;
      OVERFLOW   <= 1'b0;
    end else begin
      pend_valid <= take;
      // A drop in the START cycle still counts
      OVERFLOW   <= (OVERFLOW && !start_take) || drop;
    end
  end

  // Element and tags held for the write cycle
  always_ff @(posedge CLK) begin
    if (take) begin
      push_data        <= DATA_IN;
      push_row_last    <= row_last;
      push_matrix_last <= matrix_last;
    end
  end

endmodule

// ==== design/element_fifo.sv ====
/*
 * Circular buffer of input elements with their two tag bits
 * Occupancy count gives full and empty
 * Head entry is always shown on the read side
 */

module element_fifo (
  input  logic                                 CLK,
  input  logic                                 RST,
  // Write side
  input  logic                                 push,
  input  logic [matrix_log_pkg::DATA_SIZE-1:0] push_data,
  input  logic                                 push_row_last,
  input  logic                                 push_matrix_last,
  // Read side
  input  logic                                 pop,
  output logic [matrix_log_pkg::DATA_SIZE-1:0] pop_data,
  output logic                                 pop_row_last,
  output logic                                 pop_matrix_last,
  // Status
  output logic                                 full,
  output logic                                 empty
);

  import matrix_log_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  // Entry layout {matrix_last, row_last, data}
  logic [DATA_SIZE+1:0]     mem [FIFO_DEPTH];

  logic [FIFO_ADDR_SIZE-1:0] wr_ptr;
  logic [FIFO_ADDR_SIZE-1:0] rd_ptr;

  // One bit wider than the pointers to hold FIFO_DEPTH
  logic [FIFO_ADDR_SIZE:0]   count;

  // Writer only pushes when not full
  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= {push_matrix_last, push_row_last, push_data};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + FIFO_ADDR_SIZE'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + FIFO_ADDR_SIZE'(1);
      end
      // Simultaneous push and pop leave the count unchanged
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  // Head entry
  assign {pop_matrix_last, pop_row_last, pop_data} = mem[rd_ptr];

  assign full  = (count == FIFO_DEPTH);
  assign empty = (count == '0);

endmodule

// ==== design/log2_unit.sv ====
/*
 * Iterative base-2 log unit
 * Normalizes one bit per cycle up to the leading one, then
 * writes {position, bits below it} to the output with the strobes
 */

module log2_unit (
  input  logic                                 CLK,
  input  logic                                 RST,
  // FIFO read side
  input  logic [matrix_log_pkg::DATA_SIZE-1:0] pop_data,
  input  logic                                 pop_row_last,
  input  logic                                 pop_matrix_last,
  input  logic                                 empty,
  output logic                                 pop,
  // Result
  output logic [matrix_log_pkg::DATA_SIZE-1:0] DATA_OUT,
  output logic                                 DATA_OUT_I_ENABLE,
  output logic                                 DATA_OUT_J_ENABLE,
  output logic                                 READY
);

  import matrix_log_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  log_state_e              state;

  // Working copy of the element, shifted left until the MSB is set
  logic [DATA_SIZE-1:0]    mant;

  // Position of the leading one, counts down with each shift
  logic [LOG_INT_SIZE-1:0] exp_r;

  // Tags carried along with the element
  logic                    row_last_r;
  logic                    matrix_last_r;

  logic                    head_done;
  logic [DATA_SIZE-1:0]    result;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  // Take the head only between elements
  assign pop = (state == LOG_IDLE) && !empty;

  // Zero or already normalized, no shift needed
  assign head_done = (pop_data == '0) || pop_data[DATA_SIZE-1];

  // Leading one dropped, remainder left-aligned, low bits truncated
  assign result = (mant == '0) ? '0 :
                  {exp_r, mant[DATA_SIZE-2 -: LOG_FRAC_SIZE]};

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM and output registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state             <= LOG_IDLE;
      DATA_OUT          <= '0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;
      READY             <= 1'b0;
    end else begin
      // Strobes last one cycle
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;
      READY             <= 1'b0;
      case (state)
        LOG_IDLE: begin
          if (pop) begin
            state <= head_done ? LOG_DONE : LOG_NORM;
          end
        end
        LOG_NORM: begin
          // Bit below the MSB shifts up this cycle
          if (mant[DATA_SIZE-2]) begin
            state <= LOG_DONE;
          end
        end
        LOG_DONE: begin
          DATA_OUT          <= result;
          DATA_OUT_J_ENABLE <= 1'b1;
          DATA_OUT_I_ENABLE <= row_last_r;
          READY             <= matrix_last_r;
          state             <= LOG_IDLE;
        end
        default: begin
          state <= LOG_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Normalizer datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (pop) begin
      // Load with the top position, shifts bring it down
      mant          <= pop_data;
      exp_r         <= LOG_INT_SIZE'(DATA_SIZE - 1);
      row_last_r    <= pop_row_last;
      matrix_last_r <= pop_matrix_last;
    end else if (state == LOG_NORM) begin
      mant  <= mant << 1;
      exp_r <= exp_r - LOG_INT_SIZE'(1);
    end
  end

endmodule

// ==== design/matrix_log_top.sv ====
/*
 * Top level of the matrix log engine
 * Sequencer feeds the element FIFO, the log unit drains it
 */

module matrix_log_top (
  input  logic                                  CLK,
  input  logic                                  RST,
  // Control
  input  logic                                  START,
  input  logic                                  DATA_IN_I_ENABLE,
  input  logic                                  DATA_IN_J_ENABLE,
  output logic                                  DATA_OUT_I_ENABLE,
  output logic                                  DATA_OUT_J_ENABLE,
  output logic                                  READY,
  output logic                                  OVERFLOW,
  // Data
  input  logic [matrix_log_pkg::INDEX_SIZE-1:0] SIZE_I_IN,
  input  logic [matrix_log_pkg::INDEX_SIZE-1:0] SIZE_J_IN,
  input  logic [ matrix_log_pkg::DATA_SIZE-1:0] DATA_IN,
  output logic [ matrix_log_pkg::DATA_SIZE-1:0] DATA_OUT
);

  import matrix_log_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////////////////////////////////////////

  // Sequencer to FIFO
  logic                 push;
  logic [DATA_SIZE-1:0] push_data;
  logic                 push_row_last;
  logic                 push_matrix_last;
  logic                 full;

  // FIFO to log unit
  logic                 pop;
  logic [DATA_SIZE-1:0] pop_data;
  logic                 pop_row_last;
  logic                 pop_matrix_last;
  logic                 empty;

  ////////////////////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////////////////////

  matrix_log_sequencer u_sequencer (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .DATA_IN_I_ENABLE(DATA_IN_I_ENABLE),
    .DATA_IN_J_ENABLE(DATA_IN_J_ENABLE),
    .SIZE_I_IN       (SIZE_I_IN),
    .SIZE_J_IN       (SIZE_J_IN),
    .DATA_IN         (DATA_IN),
    .full            (full),
    .push            (push),
    .push_data       (push_data),
    .push_row_last   (push_row_last),
    .push_matrix_last(push_matrix_last),
    .OVERFLOW        (OVERFLOW)
  );

  element_fifo u_fifo (
    .CLK             (CLK),
    .RST             (RST),
    .push            (push),
    .push_data       (push_data),
    .push_row_last   (push_row_last),
    .push_matrix_last(push_matrix_last),
    .pop             (pop),
    .pop_data        (pop_data),
    .pop_row_last    (pop_row_last),
    .pop_matrix_last (pop_matrix_last),
    .full            (full),
    .empty           (empty)
  );

  // Results leave in FIFO order, so in input order
  log2_unit u_log2 (
    .CLK              (CLK),
    .RST              (RST),
    .pop_data         (pop_data),
    .pop_row_last     (pop_row_last),
    .pop_matrix_last  (pop_matrix_last),
    .empty            (empty),
    .pop              (pop),
    .DATA_OUT         (DATA_OUT),
    .DATA_OUT_I_ENABLE(DATA_OUT_I_ENABLE),
    .DATA_OUT_J_ENABLE(DATA_OUT_J_ENABLE),
    .READY            (READY)
  );

endmodule

// ==== sim/log_ref.svh ====
/*
 * Reference base-2 log in the result format of the engine
 * Queue of expected results with their strobe tags, and its push helper
 */

`ifndef LOG_REF_SVH
`define LOG_REF_SVH

// Entry layout {matrix_end, row_end, result}
logic [DATA_SIZE+1:0] exp_q [$];

// Leading-one position on top, the bits under it left-aligned below
function automatic logic [DATA_SIZE-1:0] ref_log2(input logic [DATA_SIZE-1:0] x);
  int          p;
  logic [63:0] below;
  logic [63:0] frac;
  p = -1;
  for (int b = 0; b < DATA_SIZE; b++) begin
    if (x[b]) begin
      p = b;
    end
  end
  // Zero has no leading one
  if (p < 0) begin
    return '0;
  end
  below = 64'(x) & ((64'd1 << p) - 64'd1);
  // Bit p-1 lands on the top fraction bit, lower bits fall off
  frac  = (below << LOG_FRAC_SIZE) >> p;
  return {LOG_INT_SIZE'(p), frac[LOG_FRAC_SIZE-1:0]};
endfunction

function automatic void expect_result(input logic [DATA_SIZE-1:0] d, input logic row_end,
                                      input logic matrix_end);
  exp_q.push_back({matrix_end, row_end, ref_log2(d)});
endfunction

`endif

// ==== sim/matrix_log_tb.sv ====
/*
 * Testbench for the matrix log engine
 * Clock and reset, matrix stimulus tasks, result checker on the output strobes,
 * cycle-count timeout and the closing report
 */

module matrix_log_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import matrix_log_pkg::*;

  localparam int          CLK_PERIOD     = 40;
  localparam int unsigned SEED           = 32'h41bf;
  // 40 cycles for each element of tests 2 to 5 is above the worst latency
  localparam int          ELEMS_SENT     = 12 + 20 + 9 + 13;
  localparam int          TIMEOUT_CYCLES = ELEMS_SENT * 40 + 200;

  logic                  CLK;
  logic                  RST;
  logic                  START;
  logic                  DATA_IN_I_ENABLE;
  logic                  DATA_IN_J_ENABLE;
  logic [INDEX_SIZE-1:0] SIZE_I_IN;
  logic [INDEX_SIZE-1:0] SIZE_J_IN;
  logic [DATA_SIZE-1:0]  DATA_IN;
  logic [DATA_SIZE-1:0]  DATA_OUT;
  logic                  DATA_OUT_I_ENABLE;
  logic                  DATA_OUT_J_ENABLE;
  logic                  READY;
  logic                  OVERFLOW;

  `include "log_ref.svh"

  int                    errors;
  int                    errors_at_start;
  int                    tests_run;
  int                    tests_failed;
  int                    cycle_count;
  int                    results_seen;
  int                    row_ends_seen;
  int                    ready_seen;
  logic                  ovf_allowed;
  logic [DATA_SIZE-1:0]  data_buf [$];
  logic [DATA_SIZE+1:0]  exp_entry;

  // Shapes for the strobe test
  int                    sizes_i [4] = '{1, 1, 2, 4};
  int                    sizes_j [4] = '{1, 5, 3, 2};

  matrix_log_top DUT (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .DATA_IN_I_ENABLE (DATA_IN_I_ENABLE),
    .DATA_IN_J_ENABLE (DATA_IN_J_ENABLE),
    .DATA_OUT_I_ENABLE(DATA_OUT_I_ENABLE),
    .DATA_OUT_J_ENABLE(DATA_OUT_J_ENABLE),
    .READY            (READY),
    .OVERFLOW         (OVERFLOW),
    .SIZE_I_IN        (SIZE_I_IN),
    .SIZE_J_IN        (SIZE_J_IN),
    .DATA_IN          (DATA_IN),
    .DATA_OUT         (DATA_OUT)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count++;
  end

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout after %0d cycles, %0d results never came out", cycle_count, exp_q.size());
    $display("Some tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result checker
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_low(input string name, input logic value);
    assert (value == 1'b0) else begin
      $display("[ERROR] %s got 0x%0h expected 0x0", name, value);
      errors++;
    end
  endtask

  // Outputs are read at the edge before its own updates land
  always @(posedge CLK) begin
    if (!RST) begin
      if (DATA_OUT_J_ENABLE) begin
        results_seen++;
        row_ends_seen += DATA_OUT_I_ENABLE;
        ready_seen    += READY;
        assert (exp_q.size() != 0) else begin
          $display("Result 0x%08h came out with no element outstanding", DATA_OUT);
          errors++;
        end
        if (exp_q.size() != 0) begin
          exp_entry = exp_q.pop_front();
          assert (DATA_OUT == exp_entry[DATA_SIZE-1:0]) else begin
            $display("[ERROR] DATA_OUT got 0x%08h expected 0x%08h", DATA_OUT,
                     exp_entry[DATA_SIZE-1:0]);
            errors++;
          end
          assert (DATA_OUT_I_ENABLE == exp_entry[DATA_SIZE]) else begin
            $display("[ERROR] DATA_OUT_I_ENABLE got 0x%0h expected 0x%0h", DATA_OUT_I_ENABLE,
                     exp_entry[DATA_SIZE]);
            errors++;
          end
          assert (READY == exp_entry[DATA_SIZE+1]) else begin
            $display("[ERROR] READY got 0x%0h expected 0x%0h", READY, exp_entry[DATA_SIZE+1]);
            errors++;
          end
        end
      end else begin
        // Row and matrix strobes only ride on a result
        check_low("DATA_OUT_I_ENABLE", DATA_OUT_I_ENABLE);
        check_low("READY", READY);
      end
      assert (ovf_allowed || !OVERFLOW) else begin
        $display("[ERROR] OVERFLOW got 0x%0h expected 0x0", OVERFLOW);
        errors++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [DATA_SIZE-1:0] random_word();
    // Small words give the long normalizer runs
    case ($urandom_range(2, 0))
      0:       return DATA_SIZE'($urandom_range(15, 0));
      1:       return DATA_SIZE'($urandom & 32'hffff);
      default: return DATA_SIZE'($urandom);
    endcase
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge CLK);
      START            <= 1'b0;
      DATA_IN_I_ENABLE <= 1'b0;
      DATA_IN_J_ENABLE <= 1'b0;
    end
  endtask

  task automatic start_matrix(input int si, input int sj);
    @(posedge CLK);
    START     <= 1'b1;
    SIZE_I_IN <= INDEX_SIZE'(si);
    SIZE_J_IN <= INDEX_SIZE'(sj);
    idle(1);
  endtask

  // I strobe on a row start, J strobe otherwise
  task automatic strobe_element(input logic row_start, input logic [DATA_SIZE-1:0] d);
    @(posedge CLK);
    START            <= 1'b0;
    DATA_IN          <= d;
    DATA_IN_I_ENABLE <= row_start;
    DATA_IN_J_ENABLE <= !row_start;
  endtask

  // Strobe of the kind not awaited and an optional stray START
  task automatic wrong_strobe(input logic row_start_next, input logic restart);
    @(posedge CLK);
    DATA_IN          <= $urandom;
    DATA_IN_I_ENABLE <= !row_start_next;
    DATA_IN_J_ENABLE <= row_start_next;
    START            <= restart;
    SIZE_I_IN        <= 8'd7;
    SIZE_J_IN        <= 8'd7;
  endtask

  // Sends data_buf row by row and queues each expected result as it goes out
  task automatic send_matrix(input int si, input int sj, input int max_gap, input logic noisy);
    logic [DATA_SIZE-1:0] d;
    logic                 row_end;
    int                   gap;
    start_matrix(si, sj);
    for (int i = 0; i < si; i++) begin
      for (int j = 0; j < sj; j++) begin
        // Inputs have no back-pressure so hold off while the FIFO could be full
        while (exp_q.size() >= FIFO_DEPTH) begin
          idle(1);
        end
        d       = data_buf.pop_front();
        row_end = (j == sj - 1);
        strobe_element(j == 0, d);
        expect_result(d, row_end, row_end && (i == si - 1));
        gap = noisy ? $urandom_range(max_gap, 1) : $urandom_range(max_gap, 0);
        for (int g = 0; g < gap; g++) begin
          if (noisy) begin
            wrong_strobe(row_end, (i == 1) && (j == 0) && (g == 0));
          end else begin
            idle(1);
          end
        end
      end
    end
    idle(1);
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge CLK);
    end
    idle(2);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("Test %0d %s: PASS", tests_run, name);
    end else begin
      $display("Test %0d %s: FAIL, %0d errors", tests_run, name, errors - errors_at_start);
      tests_failed++;
    end
    errors_at_start = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int rows_before;
    int ready_before;
    int results_before;
    void'($urandom(SEED));
    RST              = 1'b1;
    START            = 1'b0;
    DATA_IN_I_ENABLE = 1'b0;
    DATA_IN_J_ENABLE = 1'b0;
    SIZE_I_IN        = '0;
    SIZE_J_IN        = '0;
    DATA_IN          = '0;
    ovf_allowed      = 1'b0;
    repeat (2) @(posedge CLK);
    RST <= 1'b0;

    // Quiet outputs out of reset
    repeat (5) begin
      @(posedge CLK);
      assert (DATA_OUT == '0) else begin
        $display("[ERROR] DATA_OUT got 0x%08h expected 0x00000000", DATA_OUT);
        errors++;
      end
      check_low("DATA_OUT_I_ENABLE", DATA_OUT_I_ENABLE);
      check_low("DATA_OUT_J_ENABLE", DATA_OUT_J_ENABLE);
      check_low("READY", READY);
      check_low("OVERFLOW", OVERFLOW);
    end
    end_test("reset values");

    // 3x4 with a zero and a one among random words
    for (int k = 0; k < 12; k++) begin
      if (k == 2) begin
        data_buf.push_back('0);
      end else if (k == 7) begin
        data_buf.push_back(32'h1);
      end else begin
        data_buf.push_back(random_word());
      end
    end
    send_matrix(3, 4, 3, 1'b0);
    wait_drained();
    end_test("random 3x4 matrix");

    for (int m = 0; m < 4; m++) begin
      rows_before  = row_ends_seen;
      ready_before = ready_seen;
      repeat (sizes_i[m] * sizes_j[m]) data_buf.push_back(random_word());
      send_matrix(sizes_i[m], sizes_j[m], 2, 1'b0);
      wait_drained();
      assert (ready_seen - ready_before == 1) else begin
        $display("READY pulsed %0d times for a %0dx%0d matrix instead of once",
                 ready_seen - ready_before, sizes_i[m], sizes_j[m]);
        errors++;
      end
      assert (row_ends_seen - rows_before == sizes_i[m]) else begin
        $display("[ERROR] DATA_OUT_I_ENABLE count got 0x%0h expected 0x%0h",
                 row_ends_seen - rows_before, sizes_i[m]);
        errors++;
      end
    end
    end_test("row and matrix strobes");

    // Wrong-kind strobes in every gap and a START mid-matrix
    results_before = results_seen;
    repeat (9) data_buf.push_back(random_word());
    send_matrix(3, 3, 3, 1'b1);
    wait_drained();
    assert (results_seen - results_before == 9) else begin
      $display("Run with ignored strobes gave %0d results instead of 9",
               results_seen - results_before);
      errors++;
    end
    end_test("ignored strobes");

    // Ones take 31 shifts each so a burst overruns the FIFO
    ovf_allowed = 1'b1;
    start_matrix(2, 6);
    for (int k = 0; k < 12; k++) begin
      strobe_element((k % 6) == 0, 32'h1);
      // Eight fit in the FIFO and one in the log unit
      if (k < FIFO_DEPTH + 1) begin
        expect_result(32'h1, k == 5, 1'b0);
      end
    end
    idle(1);
    wait_drained();
    idle(40);
    assert (OVERFLOW) else begin
      $display("[ERROR] OVERFLOW got 0x%0h expected 0x1", OVERFLOW);
      errors++;
    end
    start_matrix(1, 1);
    idle(1);
    assert (!OVERFLOW) else begin
      $display("[ERROR] OVERFLOW got 0x%0h expected 0x0", OVERFLOW);
      errors++;
    end
    ovf_allowed = 1'b0;
    strobe_element(1'b1, 32'h8000_0000);
    expect_result(32'h8000_0000, 1'b1, 1'b1);
    idle(1);
    wait_drained();
    end_test("overflow burst");

    $display("Tests run %0d, passed %0d, failed %0d, results checked %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, results_seen, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== matrix_log_top.f ====
+incdir+sim
design/matrix_log_pkg.sv
design/matrix_log_sequencer.sv
design/element_fifo.sv
design/log2_unit.sv
design/matrix_log_top.sv
sim/matrix_log_tb.sv
